//--- bench/clockGen.sv
`default_nettype none

module clockGen (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Active low for the first 16 cycles
    initial begin
        reset = 1'b0;
        repeat (16) @(posedge clock);
        #1 reset = 1'b1;
    end

endmodule

`default_nettype wire

//--- bench/ddpGenBench.sv
`default_nettype none

module ddpGenBench;
    timeunit 1ns;
    timeprecision 100ps;
    import ddpPkg::*;

    localparam int MAX_RECORDS       = 128;
    localparam int CYCLES_PER_RECORD = 40;

    // Record kinds
    localparam logic [3:0] KIND_END     = 4'h0;
    localparam logic [3:0] KIND_APB_WR  = 4'h1;
    localparam logic [3:0] KIND_APB_RD  = 4'h2;
    localparam logic [3:0] KIND_PUSH    = 4'h3;
    localparam logic [3:0] KIND_EXPECT  = 4'h4;
    localparam logic [3:0] KIND_DRAIN   = 4'h5;
    localparam logic [3:0] KIND_READY   = 4'h6;

    logic                      clock;
    logic                      reset;
    logic [HDR_WIDTH-1:0]      rdmapHeader;
    logic [CTRL_WIDTH-1:0]     rdmapCtrl;
    logic                      rdmapValid;
    logic                      rdmapReady;
    logic [HDR_WIDTH-1:0]      pkgRdmapHeader;
    logic [CTRL_WIDTH-1:0]     pkgRdmapCtrl;
    logic [DDP_HDR_WIDTH-1:0]  pkgDdpHeader;
    logic [CTRL_WIDTH-1:0]     pkgDdpCtrl;
    logic                      pkgValid;
    logic                      pkgFull;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [QN_WIDTH-1:0]       pwdata;
    logic [QN_WIDTH-1:0]       prdata;
    logic                      pready;
    logic                      pslverr;

    // {kind, busy, test, rdmapHeader, rdmapCtrl, ddpHeader, ddpCtrl}
    logic [91:0] patterns [MAX_RECORDS];
    logic [91:0] expectQueue [$];
    int          recordCount;
    int          expectsIssued;
    int          wordsSeen;
    int          seed;
    logic [1:0]  busyMode;
    logic        loaded = 1'b0;

    clockGen uClockGen (
        .clock (clock),
        .reset (reset)
    );

    ddpGenTop u_dut (
        .clock          (clock),
        .reset          (reset),
        .rdmapHeader    (rdmapHeader),
        .rdmapCtrl      (rdmapCtrl),
        .rdmapValid     (rdmapValid),
        .rdmapReady     (rdmapReady),
        .pkgRdmapHeader (pkgRdmapHeader),
        .pkgRdmapCtrl   (pkgRdmapCtrl),
        .pkgDdpHeader   (pkgDdpHeader),
        .pkgDdpCtrl     (pkgDdpCtrl),
        .pkgValid       (pkgValid),
        .pkgFull        (pkgFull),
        .paddr          (paddr),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr)
    );

    // ========================================
    // Helpers
    // ========================================
    function automatic string testName(input logic [3:0] id);
        case (id)
            4'd1:    return "apbQueueTable";
            4'd2:    return "acknowledge";
            4'd3:    return "request";
            4'd4:    return "send";
            4'd5:    return "otherOpcode";
            4'd6:    return "backPressure";
            4'd7:    return "burstInput";
            default: return "unknown";
        endcase
    endfunction

    task automatic abortRun();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkValue(input string name, input logic [79:0] expected,
                              input logic [79:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            abortRun();
        end
    endtask

    // Advance one cycle, then drive pkgFull for the new cycle
    task automatic stepCycle();
        int draw;
        @(posedge clock);
        #1;
        draw = $random(seed);
        case (busyMode)
            2'd0:    pkgFull = 1'b0;
            2'd1:    pkgFull = draw[0];
            default: pkgFull = 1'b1;
        endcase
    endtask

    task automatic apbAccess(input logic write, input logic [91:0] rec);
        string name;
        name    = testName(rec[83:80]);
        paddr   = rec[43:32];
        pwrite  = write;
        pwdata  = write ? rec[23:8] : '0;
        psel    = 1'b1;
        penable = 1'b0;
        stepCycle();
        penable = 1'b1;
        @(negedge clock);
        if (write) begin
            checkValue(name, {78'd0, 1'b1, rec[0]}, {78'd0, pready, pslverr});
        end else begin
            checkValue(name, {62'd0, 1'b1, rec[0], rec[23:8]},
                       {62'd0, pready, pslverr, prdata});
        end
        stepCycle();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Ready depends on the FIFO count only, so it is settled here
    task automatic pushRecord(input logic [91:0] rec);
        rdmapHeader = rec[79:32];
        rdmapCtrl   = rec[31:24];
        rdmapValid  = 1'b1;
        while (!rdmapReady) begin
            stepCycle();
        end
        stepCycle();
        rdmapValid = 1'b0;
    endtask

    task automatic waitDrain();
        while (wordsSeen < expectsIssued) begin
            stepCycle();
        end
        repeat (3) stepCycle();
    endtask

    // ========================================
    // Output monitor
    // ========================================
    always @(negedge clock) begin : outputMonitor
        logic [91:0] expectedRec;
        if (reset && pkgValid) begin
            if (pkgFull) begin
                $display("pkgValid was raised in a cycle where pkgFull was high");
                abortRun();
            end else if (expectQueue.size() == 0) begin
                $display("an output word appeared that no pattern record expects");
                abortRun();
            end else begin
                expectedRec = expectQueue.pop_front();
                checkValue(testName(expectedRec[83:80]), expectedRec[79:0],
                           {pkgRdmapHeader, pkgRdmapCtrl, pkgDdpHeader, pkgDdpCtrl});
                wordsSeen++;
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (recordCount * CYCLES_PER_RECORD) @(posedge clock);
        $display("timeout after %0d cycles, the DUT stopped making progress",
                 recordCount * CYCLES_PER_RECORD);
        abortRun();
    end

    // ========================================
    // Stimulus
    // ========================================
    initial begin
        logic [91:0] rec;
        rdmapHeader   = '0;
        rdmapCtrl     = '0;
        rdmapValid    = 1'b0;
        pkgFull       = 1'b0;
        paddr         = '0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        pwdata        = '0;
        seed          = 32'hb2af_776d;
        busyMode      = 2'd0;
        recordCount   = 0;
        expectsIssued = 0;
        wordsSeen     = 0;
        for (int i = 0; i < MAX_RECORDS; i++) begin
            patterns[i] = '0;
        end
        $readmemh("bench/ddpPatterns.txt", patterns);
        while (recordCount < MAX_RECORDS && patterns[recordCount][91:88] != KIND_END) begin
            recordCount++;
        end
        // Expected words in output order
        for (int i = 0; i < recordCount; i++) begin
            if (patterns[i][91:88] == KIND_EXPECT) begin
                expectQueue.push_back(patterns[i]);
            end
        end
        loaded = 1'b1;

        wait (reset == 1'b1);
        stepCycle();
        for (int i = 0; i < recordCount; i++) begin
            rec      = patterns[i];
            busyMode = rec[85:84];
            case (rec[91:88])
                KIND_APB_WR: apbAccess(1'b1, rec);
                KIND_APB_RD: apbAccess(1'b0, rec);
                KIND_PUSH:   pushRecord(rec);
                KIND_EXPECT: expectsIssued++;
                KIND_DRAIN:  waitDrain();
                KIND_READY:  checkValue(testName(rec[83:80]), {79'd0, rec[0]},
                                        {79'd0, rdmapReady});
                default: begin
                    $display("pattern record %0d has an unknown kind", i);
                    abortRun();
                end
            endcase
        end

        // Idle cycles catch any late extra word
        busyMode = 2'd0;
        repeat (10) stepCycle();
        if (wordsSeen != expectsIssued || expectQueue.size() != 0) begin
            $display("run ended with %0d of %0d expected words", wordsSeen, expectsIssued);
            abortRun();
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- bench/ddpPatterns.txt
// Columns kind_busy_test_rdmapHeader_rdmapCtrl_ddpHeader_ddpCtrl
// Kind 1 apbWrite 2 apbRead 3 push 4 expect 5 drain 6 readyCheck 0 end
// Busy 0 pkgFull low 1 random pkgFull 2 pkgFull held high
// APB records carry paddr in rdmapHeader, data in ddpHeader and pslverr in ddpCtrl
1_0_1_000000000084_00_4321_00
1_0_1_000000000168_00_beef_00
1_0_1_00000000000c_00_0a5f_00
2_0_1_000000000084_00_4321_00
2_0_1_000000000168_00_beef_00
1_0_1_000000000484_00_ffff_01
2_0_1_000000000484_00_0000_01
2_0_1_000000000084_00_4321_00
// Acknowledge
3_0_2_123456789abc_47_0000_00
4_0_2_123456789abc_47_0004_c0
5_0_2_000000000000_00_0000_00
// Requests for tags 21 5a 03
3_0_3_042111223344_03_0000_00
3_0_3_025aaabbccff_13_0000_00
3_0_3_0103000000ff_03_0000_00
4_0_3_042111223344_03_0006_c0
4_0_3_025aaabbccff_13_0006_c0
4_0_3_0103000000ff_03_0006_c0
// Sends split into pieces
3_0_4_21deadbeef00_20_0000_00
3_0_4_5a0000000000_00_0000_00
3_0_4_030000000000_30_0000_00
4_0_4_21deadbeef00_20_0245_80
4_0_4_21deadbeef00_20_2434_00
4_0_4_21deadbeef00_20_4623_00
4_0_4_21deadbeef00_20_6812_40
4_0_4_5a0000000000_00_1f00_80
4_0_4_5a0000000000_00_3ccd_40
4_0_4_030000000000_30_1f00_c0
5_0_4_000000000000_00_0000_00
// Unknown opcodes are dropped
3_0_5_0123456789ab_05_0000_00
3_0_5_0000000000aa_07_0000_00
3_0_5_ffffffffffff_0f_0000_00
3_0_5_5a5a5a5a5a5a_01_0000_00
3_0_5_030000000001_00_0000_00
4_0_5_0000000000aa_07_0004_c0
4_0_5_030000000001_00_1f00_c0
5_0_5_000000000000_00_0000_00
// Random back-pressure, tag 5a rewritten to three pieces
3_1_6_210000000003_00_0000_00
3_1_6_035a0a0b0c0d_03_0000_00
3_1_6_5a0000000002_00_0000_00
3_1_6_0000000000bb_07_0000_00
4_1_6_210000000003_00_0245_80
4_1_6_210000000003_00_2434_00
4_1_6_210000000003_00_4623_00
4_1_6_210000000003_00_6812_40
4_1_6_035a0a0b0c0d_03_0006_c0
4_1_6_5a0000000002_00_1e0e_80
4_1_6_5a0000000002_00_3c0d_00
4_1_6_5a0000000002_00_5c0c_40
4_1_6_0000000000bb_07_0004_c0
5_1_6_000000000000_00_0000_00
// Burst into a held pkgFull until the FIFO is full
3_2_7_000000000001_07_0000_00
3_2_7_ffffffffffff_0c_0000_00
3_2_7_010300000010_03_0000_00
3_2_7_030000000005_00_0000_00
3_2_7_000000000002_17_0000_00
3_2_7_000000000003_27_0000_00
3_2_7_000000000004_37_0000_00
3_2_7_000000000005_47_0000_00
6_2_7_000000000000_00_0000_00
3_0_7_000000000006_57_0000_00
4_0_7_000000000001_07_0004_c0
4_0_7_010300000010_03_0006_c0
4_0_7_030000000005_00_1e11_c0
4_0_7_000000000002_17_0004_c0
4_0_7_000000000003_27_0004_c0
4_0_7_000000000004_37_0004_c0
4_0_7_000000000005_47_0004_c0
4_0_7_000000000006_57_0004_c0
5_0_7_000000000000_00_0000_00
0_0_0_000000000000_00_0000_00

//--- common/ddpPkg.sv
`default_nettype none

package ddpPkg;

    // RDMAP opcodes, low nibble of the control byte
    localparam logic [3:0] OP_SEND = 4'd0;
    localparam logic [3:0] OP_REQ  = 4'd3;
    localparam logic [3:0] OP_ACK  = 4'd7;

    localparam int HDR_WIDTH      = 48;
    localparam int CTRL_WIDTH     = 8;
    localparam int DDP_HDR_WIDTH  = 16;
    localparam int TAG_WIDTH      = 8;
    localparam int TABLE_DEPTH    = 256;
    localparam int LEN_WIDTH      = 32;
    localparam int NUM_WIDTH      = 3;
    localparam int QN_WIDTH       = 16;
    localparam int FIFO_DEPTH     = 8;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int APB_ADDR_WIDTH = 12;

    // DDP header layout {pieceId[2:0], queue[3:0], length[8:0]}
    localparam logic [15:0] REQ_DDP_HDR      = {3'd0, 4'd0, 9'd6};
    localparam logic [15:0] ACK_DDP_HDR      = {3'd0, 4'd0, 9'd4};
    localparam logic [7:0]  REQ_ACK_DDP_CTRL = 8'hC0;

    // Send FSM encoding
    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_RD_TBL = 3'd1;
    localparam logic [2:0] S_SEND   = 3'd2;
    localparam logic [2:0] S_WAIT   = 3'd3;
    localparam logic [2:0] S_POP    = 3'd4;

    // One RDMAP header word, decoded by opcode
    typedef union packed {
        struct packed {
            logic [4:0]  rsvd;
            logic [2:0]  pieceNum;
            logic [7:0]  tag;
            logic [31:0] length;
        } req;
        struct packed {
            logic [7:0]  tag;
            logic [39:0] unused;
        } send;
    } rdmapHdrU;

endpackage

`default_nettype wire

//--- common/rdmapInfoIf.sv
`default_nettype none

// Head of the RDMAP info queue
interface rdmapInfoIf;
    import ddpPkg::*;

    rdmapHdrU              header;
    logic [CTRL_WIDTH-1:0] ctrl;
    logic                  empty;
    logic                  pop;

    modport fifo (
        output header,
        output ctrl,
        output empty,
        input  pop
    );

    modport gen (
        input  header,
        input  ctrl,
        input  empty,
        output pop
    );

endinterface

`default_nettype wire

//--- ddpGen.f
common/ddpPkg.sv
common/rdmapInfoIf.sv
logic/infoFifo.sv
logic/tableRam.sv
logic/queueTable.sv
ddpGen/ddpHdrGen.sv
logic/ddpGenTop.sv
bench/clockGen.sv
bench/ddpGenBench.sv

//--- ddpGen/ddpHdrGen.sv
`default_nettype none

module ddpHdrGen (
    input  logic                             clock,
    input  logic                             reset,
    rdmapInfoIf.gen                          info,
    input  logic                             pkgFull,
    output logic                             pkgValid,
    output logic [ddpPkg::HDR_WIDTH-1:0]     pkgRdmapHeader,
    output logic [ddpPkg::CTRL_WIDTH-1:0]    pkgRdmapCtrl,
    output logic [ddpPkg::DDP_HDR_WIDTH-1:0] pkgDdpHeader,
    output logic [ddpPkg::CTRL_WIDTH-1:0]    pkgDdpCtrl,
    output logic                             numWrite,
    output logic [ddpPkg::TAG_WIDTH-1:0]     numWriteAddr,
    output logic [ddpPkg::NUM_WIDTH-1:0]     numWriteData,
    output logic                             lenWrite,
    output logic [ddpPkg::TAG_WIDTH-1:0]     lenWriteAddr,
    output logic [ddpPkg::LEN_WIDTH-1:0]     lenWriteData,
    output logic                             tableRead,
    output logic [ddpPkg::TAG_WIDTH-1:0]     tableReadAddr,
    input  logic [ddpPkg::NUM_WIDTH-1:0]     numReadData,
    input  logic [ddpPkg::LEN_WIDTH-1:0]     lenReadData,
    output logic                             queueRd,
    output logic [ddpPkg::TAG_WIDTH-1:0]     queueRdAddr,
    input  logic [ddpPkg::QN_WIDTH-1:0]      queueRdData
);
    import ddpPkg::*;

    logic [3:0]               opcode;
    logic                     idle;
    logic                     isReq;
    logic                     isAck;
    logic                     isSend;
    logic                     isOther;
    logic                     reqAckGo;
    logic [2:0]               state;
    logic [2:0]               nextState;
    logic                     tableDataValid;
    logic [NUM_WIDTH-1:0]     numHeld;
    logic [LEN_WIDTH-1:0]     lenHeld;
    logic [QN_WIDTH-1:0]      qnHeld;
    logic [NUM_WIDTH-1:0]     sendNum;
    logic [LEN_WIDTH-1:0]     sendLen;
    logic [QN_WIDTH-1:0]      sendQn;
    logic [NUM_WIDTH-1:0]     pieceIdx;
    logic                     lastPiece;
    logic                     sendOnePiece;
    logic [8:0]               pieceLen;
    logic [3:0]               pieceQn;
    logic [DDP_HDR_WIDTH-1:0] sendHdr;
    logic [CTRL_WIDTH-1:0]    sendCtrl;

    // ========================================
    // Opcode decode
    // ========================================
    assign opcode  = info.ctrl[3:0];
    assign idle    = (state == S_IDLE);
    assign isReq   = ~info.empty & idle & (opcode == OP_REQ);
    assign isAck   = ~info.empty & idle & (opcode == OP_ACK);
    assign isSend  = ~info.empty & idle & (opcode == OP_SEND);
    assign isOther = ~info.empty & idle & (opcode != OP_REQ) & (opcode != OP_ACK)
                     & (opcode != OP_SEND);

    assign reqAckGo = (isReq | isAck) & ~pkgFull;

    // Request records its transfer shape
    assign numWrite     = isReq & ~pkgFull;
    assign numWriteAddr = info.header.req.tag;
    assign numWriteData = info.header.req.pieceNum;
    assign lenWrite     = isReq & ~pkgFull;
    assign lenWriteAddr = info.header.req.tag;
    assign lenWriteData = info.header.req.length;

    // ========================================
    // Send FSM
    // ========================================
    assign tableRead     = (state == S_RD_TBL);
    assign tableReadAddr = info.header.send.tag;
    assign queueRd       = (state == S_RD_TBL);
    assign queueRdAddr   = info.header.send.tag;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state          <= S_IDLE;
            tableDataValid <= 1'b0;
            pieceIdx       <= '0;
        end else begin
            state          <= nextState;
            tableDataValid <= tableRead;
            if (sendOnePiece) begin
                pieceIdx <= lastPiece ? '0 : pieceIdx + 1'b1;
            end
        end
    end

    // Hold the table results for the rest of the send
    always_ff @(posedge clock) begin
        if (tableDataValid) begin
            numHeld <= numReadData;
            lenHeld <= lenReadData;
            qnHeld  <= queueRdData;
        end
    end

    assign sendNum = tableDataValid ? numReadData : numHeld;
    assign sendLen = tableDataValid ? lenReadData : lenHeld;
    assign sendQn  = tableDataValid ? queueRdData : qnHeld;

    assign sendOnePiece = ((state == S_SEND) | (state == S_WAIT)) & ~pkgFull;
    assign lastPiece    = (pieceIdx == sendNum - 1'b1);

    always_comb begin
        nextState = state;
        case (state)
            S_IDLE: begin
                if (isSend) begin
                    nextState = S_RD_TBL;
                end
            end
            S_RD_TBL: nextState = S_SEND;
            S_SEND, S_WAIT: begin
                if (sendOnePiece && lastPiece) begin
                    nextState = S_POP;
                end else if (pkgFull) begin
                    nextState = S_WAIT;
                end else begin
                    nextState = S_SEND;
                end
            end
            S_POP:   nextState = S_IDLE;
            default: nextState = S_IDLE;
        endcase
    end

    // Piece k takes byte k of the length and nibble k of the queue word
    assign pieceLen = {1'b0, sendLen[{pieceIdx[1:0], 3'b000} +: 8]} + 9'd1;
    assign pieceQn  = sendQn[{pieceIdx[1:0], 2'b00} +: 4];
    assign sendHdr  = {pieceIdx, pieceQn, pieceLen};
    assign sendCtrl = {(pieceIdx == '0), lastPiece, 6'd0};

    // ========================================
    // Output mux and pop
    // ========================================
    assign pkgValid       = sendOnePiece | reqAckGo;
    assign pkgDdpHeader   = sendOnePiece ? sendHdr :
                            isReq        ? REQ_DDP_HDR : ACK_DDP_HDR;
    assign pkgDdpCtrl     = sendOnePiece ? sendCtrl : REQ_ACK_DDP_CTRL;
    assign pkgRdmapHeader = info.header;
    assign pkgRdmapCtrl   = info.ctrl;

    // Unknown opcodes are dropped
    assign info.pop = ~info.empty & ((state == S_POP) | reqAckGo | (isOther & ~pkgFull));

    assert property (@(posedge clock) disable iff (!reset)
        tableDataValid |-> (numReadData >= 3'd1 && numReadData <= 3'd4))
        else $error("ddpHdrGen piece count out of range");

endmodule

`default_nettype wire

//--- logic/ddpGenTop.sv
`default_nettype none

module ddpGenTop (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [ddpPkg::HDR_WIDTH-1:0]      rdmapHeader,
    input  logic [ddpPkg::CTRL_WIDTH-1:0]     rdmapCtrl,
    input  logic                              rdmapValid,
    output logic                              rdmapReady,
    output logic [ddpPkg::HDR_WIDTH-1:0]      pkgRdmapHeader,
    output logic [ddpPkg::CTRL_WIDTH-1:0]     pkgRdmapCtrl,
    output logic [ddpPkg::DDP_HDR_WIDTH-1:0]  pkgDdpHeader,
    output logic [ddpPkg::CTRL_WIDTH-1:0]     pkgDdpCtrl,
    output logic                              pkgValid,
    input  logic                              pkgFull,
    input  logic [ddpPkg::APB_ADDR_WIDTH-1:0] paddr,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [ddpPkg::QN_WIDTH-1:0]       pwdata,
    output logic [ddpPkg::QN_WIDTH-1:0]       prdata,
    output logic                              pready,
    output logic                              pslverr
);
    import ddpPkg::*;

    logic                 fifoFull;
    logic                 fifoPush;
    logic                 numWrite;
    logic [TAG_WIDTH-1:0] numWriteAddr;
    logic [NUM_WIDTH-1:0] numWriteData;
    logic [NUM_WIDTH-1:0] numReadData;
    logic                 lenWrite;
    logic [TAG_WIDTH-1:0] lenWriteAddr;
    logic [LEN_WIDTH-1:0] lenWriteData;
    logic [LEN_WIDTH-1:0] lenReadData;
    logic                 tableRead;
    logic [TAG_WIDTH-1:0] tableReadAddr;
    logic                 queueRd;
    logic [TAG_WIDTH-1:0] queueRdAddr;
    logic [QN_WIDTH-1:0]  queueRdData;

    rdmapInfoIf infoHead ();

    assign rdmapReady = ~fifoFull;
    assign fifoPush   = rdmapValid & rdmapReady;

    infoFifo uInfoFifo (
        .clock    (clock),
        .reset    (reset),
        .push     (fifoPush),
        .pushData ({rdmapCtrl, rdmapHeader}),
        .full     (fifoFull),
        .head     (infoHead.fifo)
    );

    tableRam #(.Width(NUM_WIDTH)) uNumTable (
        .clock       (clock),
        .writeEnable (numWrite),
        .writeAddr   (numWriteAddr),
        .writeData   (numWriteData),
        .readEnable  (tableRead),
        .readAddr    (tableReadAddr),
        .readData    (numReadData)
    );

    tableRam #(.Width(LEN_WIDTH)) uLenTable (
        .clock       (clock),
        .writeEnable (lenWrite),
        .writeAddr   (lenWriteAddr),
        .writeData   (lenWriteData),
        .readEnable  (tableRead),
        .readAddr    (tableReadAddr),
        .readData    (lenReadData)
    );

    queueTable uQueueTable (
        .clock       (clock),
        .reset       (reset),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .queueRd     (queueRd),
        .queueRdAddr (queueRdAddr),
        .queueRdData (queueRdData)
    );

    ddpHdrGen uDdpHdrGen (
        .clock          (clock),
        .reset          (reset),
        .info           (infoHead.gen),
        .pkgFull        (pkgFull),
        .pkgValid       (pkgValid),
        .pkgRdmapHeader (pkgRdmapHeader),
        .pkgRdmapCtrl   (pkgRdmapCtrl),
        .pkgDdpHeader   (pkgDdpHeader),
        .pkgDdpCtrl     (pkgDdpCtrl),
        .numWrite       (numWrite),
        .numWriteAddr   (numWriteAddr),
        .numWriteData   (numWriteData),
        .lenWrite       (lenWrite),
        .lenWriteAddr   (lenWriteAddr),
        .lenWriteData   (lenWriteData),
        .tableRead      (tableRead),
        .tableReadAddr  (tableReadAddr),
        .numReadData    (numReadData),
        .lenReadData    (lenReadData),
        .queueRd        (queueRd),
        .queueRdAddr    (queueRdAddr),
        .queueRdData    (queueRdData)
    );

endmodule

`default_nettype wire

//--- logic/infoFifo.sv
`default_nettype none

module infoFifo (
    input  logic                                            clock,
    input  logic                                            reset,
    input  logic                                            push,
    input  logic [ddpPkg::CTRL_WIDTH+ddpPkg::HDR_WIDTH-1:0] pushData,
    output logic                                            full,
    rdmapInfoIf.fifo                                        head
);
    import ddpPkg::*;

    logic [CTRL_WIDTH+HDR_WIDTH-1:0] entries [FIFO_DEPTH];
    logic [FIFO_PTR_WIDTH-1:0]       wrPtr;
    logic [FIFO_PTR_WIDTH-1:0]       rdPtr;
    logic [FIFO_PTR_WIDTH:0]         count;

    // Depth is a power of two, so the count MSB alone means full
    assign full       = count[FIFO_PTR_WIDTH];
    assign head.empty = (count == '0);

    // First word falls through
    assign head.header = entries[rdPtr][HDR_WIDTH-1:0];
    assign head.ctrl   = entries[rdPtr][CTRL_WIDTH+HDR_WIDTH-1:HDR_WIDTH];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (head.pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, head.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            entries[wrPtr] <= pushData;
        end
    end

    // Producer and consumer both respect the flags
    assert property (@(posedge clock) disable iff (!reset) !(push && full))
        else $error("infoFifo push while full");
    assert property (@(posedge clock) disable iff (!reset) !(head.pop && head.empty))
        else $error("infoFifo pop while empty");

endmodule

`default_nettype wire

//--- logic/queueTable.sv
`default_nettype none

module queueTable (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [ddpPkg::APB_ADDR_WIDTH-1:0] paddr,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [ddpPkg::QN_WIDTH-1:0]       pwdata,
    output logic [ddpPkg::QN_WIDTH-1:0]       prdata,
    output logic                              pready,
    output logic                              pslverr,
    input  logic                              queueRd,
    input  logic [ddpPkg::TAG_WIDTH-1:0]      queueRdAddr,
    output logic [ddpPkg::QN_WIDTH-1:0]       queueRdData
);
    import ddpPkg::*;

    logic [QN_WIDTH-1:0]  queueNum [TABLE_DEPTH];
    logic [TAG_WIDTH-1:0] wordIndex;
    logic                 addrError;
    logic                 setupPhase;
    logic                 accessPhase;

    // Word index in paddr[9:2], upper bits must be zero
    assign wordIndex   = paddr[TAG_WIDTH+1:2];
    assign addrError   = |paddr[APB_ADDR_WIDTH-1:TAG_WIDTH+2];
    assign setupPhase  = psel & ~penable;
    assign accessPhase = psel & penable;

    // Zero wait states
    assign pready  = accessPhase;
    assign pslverr = accessPhase & addrError;

    always_ff @(posedge clock) begin
        if (accessPhase && pwrite && !addrError) begin
            queueNum[wordIndex] <= pwdata;
        end
        if (queueRd) begin
            queueRdData <= queueNum[queueRdAddr];
        end
    end

    // Fetched during setup so it is valid in the access phase
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            prdata <= '0;
        end else if (setupPhase && !pwrite) begin
            prdata <= addrError ? '0 : queueNum[wordIndex];
        end
    end

    assert property (@(posedge clock) disable iff (!reset) penable |-> psel)
        else $error("queueTable penable without psel");

endmodule

`default_nettype wire

//--- logic/tableRam.sv
`default_nettype none

module tableRam #(
    parameter int Width = 32
) (
    input  logic                         clock,
    input  logic                         writeEnable,
    input  logic [ddpPkg::TAG_WIDTH-1:0] writeAddr,
    input  logic [Width-1:0]             writeData,
    input  logic                         readEnable,
    input  logic [ddpPkg::TAG_WIDTH-1:0] readAddr,
    output logic [Width-1:0]             readData
);
    import ddpPkg::*;

    logic [Width-1:0] store [TABLE_DEPTH];

    // Same-entry write and read in one cycle returns the old word
    always_ff @(posedge clock) begin
        if (writeEnable) begin
            store[writeAddr] <= writeData;
        end
        if (readEnable) begin
            readData <= store[readAddr];
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
    --timescale 1ns/100ps \
    -f ddpGen.f \
    --top-module ddpGenBench \
    -o ddpGenSim

./obj_dir/ddpGenSim
